// File: verilog/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

    // data word, also used for exception codes and addresses
    typedef logic [31:0] word_t;

    // one bit per stage: pc in bit 0, then if, id, ex, mem, wb
    typedef logic [5:0] stall_t;

    // stall requests raised by the stages, pc in bit 0
    typedef struct packed {
        logic from_mem;
        logic from_ex;
        logic from_id;
        logic from_if;
        logic from_pc;
    } stall_req_t;

    // requesting stage and everything ahead of it hold
    localparam stall_t STALL_MEM = 6'b011110;
    localparam stall_t STALL_EX  = 6'b001110;
    localparam stall_t STALL_ID  = 6'b000110;
    localparam stall_t STALL_IF  = 6'b000010;
    localparam stall_t STALL_PC  = 6'b000001;

    // exception codes from the memory stage
    localparam word_t EXC_INT      = 32'h0000_0001;
    localparam word_t EXC_SYSCALL  = 32'h0000_0008;
    localparam word_t EXC_INVALID  = 32'h0000_000a;
    localparam word_t EXC_OVERFLOW = 32'h0000_000c;
    localparam word_t EXC_TRAP     = 32'h0000_000d;
    localparam word_t EXC_ERET     = 32'h0000_000e;

    // vector values out of reset
    localparam word_t INT_VECTOR_RST = 32'h0000_0020;
    localparam word_t EXC_VECTOR_RST = 32'h0000_0040;

endpackage

`default_nettype wire

// File: verilog/apb_pkg.sv
`default_nettype none

package apb_pkg;

    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // register map
    localparam apb_addr_t ADDR_INT_VEC = 4'h0;
    localparam apb_addr_t ADDR_EXC_VEC = 4'h4;
    // read-only
    localparam apb_addr_t ADDR_CAUSE   = 4'h8;
    localparam apb_addr_t ADDR_COUNT   = 4'hC;

endpackage

`default_nettype wire

// File: verilog/stall_ctrl.sv
`default_nettype none

module stall_ctrl (
    input  pipe_ctrl_pkg::stall_req_t stall_req,
    input  logic                      flush,
    output pipe_ctrl_pkg::stall_t     stall
);

    import pipe_ctrl_pkg::*;

    // deepest requesting stage wins, later stages keep draining
    always_comb begin
        if (flush) begin
            // flushed pipeline restarts, nothing to hold
            stall = '0;
        end else if (stall_req.from_mem) begin
            stall = STALL_MEM;
        end else if (stall_req.from_ex) begin
            stall = STALL_EX;
        end else if (stall_req.from_id) begin
            stall = STALL_ID;
        end else if (stall_req.from_if) begin
            stall = STALL_IF;
        end else if (stall_req.from_pc) begin
            stall = STALL_PC;
        end else begin
            stall = '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/except_fsm.sv
`default_nettype none

module except_fsm (
    input  logic                 clk,
    input  logic                 reset,
    input  pipe_ctrl_pkg::word_t excepttype,
    input  logic                 drain_done,
    output logic                 accept,
    output logic                 flush,
    output logic                 drain_start
);

    import pipe_ctrl_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FLUSH,
        DRAIN
    } state_t;

    state_t state;
    state_t state_next;
    logic   code_known;

    // zero and unknown codes never start a flush
    always_comb begin
        case (excepttype)
            EXC_INT,
            EXC_SYSCALL,
            EXC_INVALID,
            EXC_OVERFLOW,
            EXC_TRAP,
            EXC_ERET: begin
                code_known = 1'b1;
            end
            default: begin
                code_known = 1'b0;
            end
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (code_known) begin
                    state_next = FLUSH;
                end
            end
            FLUSH: begin
                // a one-cycle window already ends here
                state_next = drain_done ? IDLE : DRAIN;
            end
            DRAIN: begin
                if (drain_done) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // codes outside idle are dropped
    assign accept      = (state == IDLE) && code_known;
    assign flush       = (state == FLUSH);
    assign drain_start = (state == FLUSH);

endmodule

`default_nettype wire

// File: verilog/drain_timer.sv
`default_nettype none

module drain_timer #(
    parameter int FLUSH_CYCLES = 3
) (
    input  logic clk,
    input  logic reset,
    input  logic drain_start,
    output logic drain_done
);

    localparam int CNT_W = $clog2(FLUSH_CYCLES + 1);

    // cycles left in the window after the flush cycle
    logic [CNT_W-1:0] remaining;

    always_ff @(posedge clk) begin
        if (reset) begin
            remaining <= '0;
        end else if (drain_start) begin
            remaining <= CNT_W'(FLUSH_CYCLES - 1);
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    // done marks the last cycle of the window, the flush cycle itself when only one
    assign drain_done = (FLUSH_CYCLES == 1) ? drain_start : (remaining == CNT_W'(1));

endmodule

`default_nettype wire

// File: verilog/except_regs.sv
`default_nettype none

module except_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  apb_pkg::apb_req_t    apb_req,
    output apb_pkg::apb_rsp_t    apb_rsp,
    input  logic                 accept,
    input  logic                 flush,
    input  pipe_ctrl_pkg::word_t excepttype,
    input  pipe_ctrl_pkg::word_t cp0_epc,
    output pipe_ctrl_pkg::word_t new_pc
);

    import pipe_ctrl_pkg::*;
    import apb_pkg::*;

    word_t int_vec;
    word_t exc_vec;
    word_t cause;
    word_t epc;
    word_t exc_count;

    logic apb_access;
    logic addr_mapped;
    logic addr_writable;
    logic reg_write;

    assign apb_access = apb_req.psel && apb_req.penable;

    always_comb begin
        case (apb_req.paddr)
            ADDR_INT_VEC, ADDR_EXC_VEC: begin
                addr_mapped   = 1'b1;
                addr_writable = 1'b1;
            end
            ADDR_CAUSE, ADDR_COUNT: begin
                addr_mapped   = 1'b1;
                addr_writable = 1'b0;
            end
            default: begin
                addr_mapped   = 1'b0;
                addr_writable = 1'b0;
            end
        endcase
    end

    // bad writes are dropped here and flagged below
    assign reg_write = apb_access && apb_req.pwrite && addr_writable;

    always_ff @(posedge clk) begin
        if (reset) begin
            int_vec <= INT_VECTOR_RST;
            exc_vec <= EXC_VECTOR_RST;
        end else if (reg_write) begin
            if (apb_req.paddr == ADDR_INT_VEC) begin
                int_vec <= apb_req.pwdata;
            end else begin
                exc_vec <= apb_req.pwdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause     <= '0;
            exc_count <= '0;
        end else begin
            if (accept) begin
                cause <= excepttype;
            end
            if (flush) begin
                exc_count <= exc_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            epc <= cp0_epc;
        end
    end

    // no wait states
    always_comb begin
        apb_rsp        = '0;
        apb_rsp.pready = 1'b1;
        if (apb_access && !apb_req.pwrite) begin
            case (apb_req.paddr)
                ADDR_INT_VEC: apb_rsp.prdata = int_vec;
                ADDR_EXC_VEC: apb_rsp.prdata = exc_vec;
                ADDR_CAUSE:   apb_rsp.prdata = cause;
                ADDR_COUNT:   apb_rsp.prdata = exc_count;
                default:      apb_rsp.prdata = '0;
            endcase
        end
        apb_rsp.pslverr = apb_access && (!addr_mapped || (apb_req.pwrite && !addr_writable));
    end

    // redirect from the cause captured one cycle earlier
    always_comb begin
        new_pc = '0;
        if (flush) begin
            case (cause)
                EXC_INT:  new_pc = int_vec;
                EXC_ERET: new_pc = epc;
                default:  new_pc = exc_vec;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/pipe_ctrl_top.sv
`default_nettype none

module pipe_ctrl_top #(
    parameter int FLUSH_CYCLES = 3
) (
    input  logic                      clk,
    input  logic                      reset,
    input  pipe_ctrl_pkg::stall_req_t stall_req,
    input  pipe_ctrl_pkg::word_t      excepttype,
    input  pipe_ctrl_pkg::word_t      cp0_epc,
    input  apb_pkg::apb_req_t         apb_req,
    output apb_pkg::apb_rsp_t         apb_rsp,
    output pipe_ctrl_pkg::stall_t     stall,
    output logic                      flush,
    output pipe_ctrl_pkg::word_t      new_pc
);

    logic accept;
    logic drain_start;
    logic drain_done;

    stall_ctrl u_stall_ctrl (
        .stall_req (stall_req),
        .flush     (flush),
        .stall     (stall)
    );

    except_fsm u_except_fsm (
        .clk         (clk),
        .reset       (reset),
        .excepttype  (excepttype),
        .drain_done  (drain_done),
        .accept      (accept),
        .flush       (flush),
        .drain_start (drain_start)
    );

    drain_timer #(
        .FLUSH_CYCLES (FLUSH_CYCLES)
    ) u_drain_timer (
        .clk         (clk),
        .reset       (reset),
        .drain_start (drain_start),
        .drain_done  (drain_done)
    );

    except_regs u_except_regs (
        .clk        (clk),
        .reset      (reset),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .accept     (accept),
        .flush      (flush),
        .excepttype (excepttype),
        .cp0_epc    (cp0_epc),
        .new_pc     (new_pc)
    );

endmodule

`default_nettype wire

// File: testbench/pipe_ctrl_props.sv
`default_nettype none

module pipe_ctrl_props #(
    parameter int FLUSH_CYCLES = 3
) (
    input logic                      clk,
    input logic                      reset,
    input pipe_ctrl_pkg::stall_req_t stall_req,
    input pipe_ctrl_pkg::word_t      excepttype,
    input pipe_ctrl_pkg::word_t      cp0_epc,
    input apb_pkg::apb_req_t         apb_req,
    input pipe_ctrl_pkg::stall_t     stall,
    input logic                      flush,
    input pipe_ctrl_pkg::word_t      new_pc
);

    timeunit 1ns;
    timeprecision 100ps;

    import pipe_ctrl_pkg::*;
    import apb_pkg::*;

    int     assert_fails = 0;
    int     busy;
    logic   take;
    logic   exp_flush;
    word_t  exp_code;
    word_t  exp_epc;
    word_t  int_vec;
    word_t  exc_vec;
    word_t  exp_pc;
    stall_t exp_stall;

    // a known code seen while no drain window is open
    assign take = !reset && (busy == 0) && (excepttype inside {EXC_INT, EXC_SYSCALL,
                  EXC_INVALID, EXC_OVERFLOW, EXC_TRAP, EXC_ERET});

    always_comb begin
        casez (stall_req)
            5'b1????: exp_stall = STALL_MEM;
            5'b01???: exp_stall = STALL_EX;
            5'b001??: exp_stall = STALL_ID;
            5'b0001?: exp_stall = STALL_IF;
            5'b00001: exp_stall = STALL_PC;
            default:  exp_stall = '0;
        endcase
    end

    always_comb begin
        case (exp_code)
            EXC_INT:  exp_pc = int_vec;
            EXC_ERET: exp_pc = exp_epc;
            default:  exp_pc = exc_vec;
        endcase
    end

    // window covers the flush cycle and the drain after it
    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 0;
            exp_flush <= 1'b0;
            int_vec   <= INT_VECTOR_RST;
            exc_vec   <= EXC_VECTOR_RST;
        end else begin
            exp_flush <= take;
            if (take) begin
                busy     <= FLUSH_CYCLES;
                exp_code <= excepttype;
                exp_epc  <= cp0_epc;
            end else if (busy != 0) begin
                busy <= busy - 1;
            end
            if (apb_req.psel && apb_req.penable && apb_req.pwrite) begin
                if (apb_req.paddr == ADDR_INT_VEC) begin
                    int_vec <= apb_req.pwdata;
                end
                if (apb_req.paddr == ADDR_EXC_VEC) begin
                    exc_vec <= apb_req.pwdata;
                end
            end
        end
    end

    a_stall: assert property (@(posedge clk) disable iff (reset)
        stall == (exp_flush ? stall_t'(0) : exp_stall))
        else begin
            $error("Fail %0t: stall %b, expected %b", $time, stall,
                   exp_flush ? stall_t'(0) : exp_stall);
            assert_fails++;
        end

    a_flush: assert property (@(posedge clk) disable iff (reset)
        flush == exp_flush)
        else begin
            $error("Fail %0t: flush %b, expected %b", $time, flush, exp_flush);
            assert_fails++;
        end

    a_redirect: assert property (@(posedge clk) disable iff (reset)
        new_pc == (exp_flush ? exp_pc : word_t'(0)))
        else begin
            $error("Fail %0t: new_pc %h, expected %h", $time, new_pc,
                   exp_flush ? exp_pc : word_t'(0));
            assert_fails++;
        end

endmodule

bind pipe_ctrl_top pipe_ctrl_props #(
    .FLUSH_CYCLES (FLUSH_CYCLES)
) u_props (
    .clk        (clk),
    .reset      (reset),
    .stall_req  (stall_req),
    .excepttype (excepttype),
    .cp0_epc    (cp0_epc),
    .apb_req    (apb_req),
    .stall      (stall),
    .flush      (flush),
    .new_pc     (new_pc)
);

`default_nettype wire

// File: testbench/tb_pipe_ctrl.sv
`default_nettype none

module tb_pipe_ctrl;

    timeunit 1ns;
    timeprecision 100ps;

    import pipe_ctrl_pkg::*;
    import apb_pkg::*;

    localparam int FLUSH_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = 400;

    logic       clk;
    logic       reset;
    stall_req_t stall_req;
    word_t      excepttype;
    word_t      cp0_epc;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    stall_t     stall;
    logic       flush;
    word_t      new_pc;

    int    cycles = 0;
    int    flushes_seen = 0;
    int    tb_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    fails_before = 0;
    word_t last_code;
    word_t int_vec;
    word_t exc_vec;
    word_t known_codes [6] = '{EXC_INT, EXC_SYSCALL, EXC_INVALID,
                               EXC_OVERFLOW, EXC_TRAP, EXC_ERET};
    word_t odd_codes [4] = '{32'h5, 32'h2, 32'hff, 32'h1000_0001};

    pipe_ctrl_top #(
        .FLUSH_CYCLES (FLUSH_CYCLES)
    ) u_dut (
        .clk        (clk),
        .reset      (reset),
        .stall_req  (stall_req),
        .excepttype (excepttype),
        .cp0_epc    (cp0_epc),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .stall      (stall),
        .flush      (flush),
        .new_pc     (new_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog and flush count sampled mid-cycle
    always @(negedge clk) begin
        cycles++;
        if (!reset && flush) begin
            flushes_seen++;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic int total_fails();
        return tb_errors + u_dut.u_props.assert_fails;
    endfunction

    task automatic finish_test(input string name);
        int new_fails;
        new_fails = total_fails() - fails_before;
        tests_run++;
        if (new_fails == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, new_fails);
        end
        fails_before = total_fails();
    endtask

    // data holds the write data or the expected read data
    task automatic apb_xfer(input logic write, input apb_addr_t addr, input word_t data,
                            input logic expect_err);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = write ? data : '0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        if (apb_rsp.pready !== 1'b1) begin
            $display("Fail %0t: pready %b at addr %h, expected 1",
                     $time, apb_rsp.pready, addr);
            tb_errors++;
        end
        if (apb_rsp.pslverr !== expect_err) begin
            $display("Fail %0t: pslverr %b at addr %h, expected %b",
                     $time, apb_rsp.pslverr, addr, expect_err);
            tb_errors++;
        end else if (!write && !expect_err && apb_rsp.prdata !== data) begin
            $display("Fail %0t: read %h at addr %h, expected %h",
                     $time, apb_rsp.prdata, addr, data);
            tb_errors++;
        end
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic take_exception(input word_t code, input word_t epc);
        int waited;
        waited = 0;
        @(negedge clk);
        excepttype = code;
        cp0_epc    = epc;
        do begin
            @(negedge clk);
            waited++;
        end while (!flush && waited < 2 * FLUSH_CYCLES);
        excepttype = '0;
        // the epc seen at acceptance must survive a change here
        cp0_epc    = $urandom;
        if (!flush) begin
            $display("Fail %0t: code %h produced no flush", $time, code);
            tb_errors++;
        end else begin
            last_code = code;
        end
        repeat (FLUSH_CYCLES) @(negedge clk);
    endtask

    initial begin
        void'($urandom(16551));
        reset      = 1'b1;
        stall_req  = '0;
        excepttype = '0;
        cp0_epc    = '0;
        apb_req    = '0;
        last_code  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        apb_xfer(1'b0, ADDR_INT_VEC, INT_VECTOR_RST, 1'b0);
        apb_xfer(1'b0, ADDR_EXC_VEC, EXC_VECTOR_RST, 1'b0);
        apb_xfer(1'b0, ADDR_CAUSE, '0, 1'b0);
        apb_xfer(1'b0, ADDR_COUNT, '0, 1'b0);
        finish_test("apb_reset");

        // each single request once, then none
        for (int b = 0; b < 5; b++) begin
            @(negedge clk);
            stall_req = 5'(1 << b);
        end
        @(negedge clk);
        stall_req = '0;
        repeat (40) begin
            @(negedge clk);
            stall_req = 5'($urandom);
        end
        finish_test("stall_priority");

        // every stage requesting so the flush has to win
        stall_req = '1;
        foreach (known_codes[i]) begin
            take_exception(known_codes[i], $urandom);
        end
        stall_req = '0;
        finish_test("exception_redirect");

        foreach (odd_codes[i]) begin
            @(negedge clk);
            excepttype = odd_codes[i];
            repeat (2) @(negedge clk);
        end
        excepttype = '0;
        finish_test("ignored_codes");

        // held code is taken once per window
        @(negedge clk);
        excepttype = EXC_SYSCALL;
        repeat (3 * (FLUSH_CYCLES + 1)) @(negedge clk);
        excepttype = '0;
        last_code  = EXC_SYSCALL;
        repeat (FLUSH_CYCLES + 1) @(negedge clk);
        excepttype = EXC_TRAP;
        @(negedge clk);
        // present only while draining
        excepttype = EXC_OVERFLOW;
        repeat (FLUSH_CYCLES) @(negedge clk);
        excepttype = '0;
        last_code  = EXC_TRAP;
        repeat (FLUSH_CYCLES + 1) @(negedge clk);
        finish_test("drain_window");

        int_vec = $urandom;
        exc_vec = $urandom;
        apb_xfer(1'b1, ADDR_INT_VEC, int_vec, 1'b0);
        apb_xfer(1'b1, ADDR_EXC_VEC, exc_vec, 1'b0);
        apb_xfer(1'b0, ADDR_INT_VEC, int_vec, 1'b0);
        apb_xfer(1'b0, ADDR_EXC_VEC, exc_vec, 1'b0);
        take_exception(EXC_INT, $urandom);
        take_exception(EXC_OVERFLOW, $urandom);
        apb_xfer(1'b0, ADDR_CAUSE, last_code, 1'b0);
        apb_xfer(1'b0, ADDR_COUNT, flushes_seen, 1'b0);
        apb_xfer(1'b1, ADDR_CAUSE, 32'hffff_ffff, 1'b1);
        apb_xfer(1'b1, ADDR_COUNT, 32'hffff_ffff, 1'b1);
        apb_xfer(1'b1, 4'h2, ~int_vec, 1'b1);
        apb_xfer(1'b0, 4'h6, '0, 1'b1);
        apb_xfer(1'b0, ADDR_INT_VEC, int_vec, 1'b0);
        apb_xfer(1'b0, ADDR_EXC_VEC, exc_vec, 1'b0);
        apb_xfer(1'b0, ADDR_CAUSE, last_code, 1'b0);
        apb_xfer(1'b0, ADDR_COUNT, flushes_seen, 1'b0);
        finish_test("apb_registers");

        $display("tests run %0d, failed %0d, check failures %0d",
                 tests_run, tests_failed, total_fails());
        if (total_fails() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/pipe_ctrl_pkg.sv
verilog/apb_pkg.sv
verilog/stall_ctrl.sv
verilog/except_fsm.sv
verilog/drain_timer.sv
verilog/except_regs.sv
verilog/pipe_ctrl_top.sv
testbench/pipe_ctrl_props.sv
testbench/tb_pipe_ctrl.sv

// File: Makefile
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module tb_pipe_ctrl -Mdir $(OBJ_DIR) -f verilog.f
	$(OBJ_DIR)/Vtb_pipe_ctrl +verilator+error+limit+100 | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
